// File: vga_game.f
src/vga_pkg.sv
src/vga_timing.sv
src/screen_regs.sv
src/finish_screen.sv
src/vga_out_stage.sv
src/vga_game_top.sv
bench/vga_game_props.sv
bench/vga_game_tb.sv

// File: Makefile
# Verilator build and run of the VGA game display testbench

VERILATOR ?= verilator
TOP       ?= vga_game_tb
FILELIST  ?= vga_game.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= Test OK

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass or fail is decided by the pass line in the output
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// File: bench/vga_game_tb.sv
`default_nettype none
`timescale 1ns/1ps

module vga_game_tb;

    import vga_pkg::*;

    localparam int FRAME_CYCLES = int'(HOR_TOTAL) * int'(VER_TOTAL);
    localparam int SYNC_LIMIT   = 2 * FRAME_CYCLES;
    localparam int WB_LIMIT     = 16;

    logic        clk;
    logic        rst;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [1:0]  wb_adr;
    logic [31:0] wb_wdata;
    logic [31:0] wb_rdata;
    logic        wb_ack;
    logic        vga_hsync;
    logic        vga_vsync;
    logic [3:0]  vga_r;
    logic [3:0]  vga_g;
    logic [3:0]  vga_b;
    integer      seed;

    logic               aligned    = 1'b0;  // model locked to the pins
    logic               vsync_prev = 1'b0;
    logic [COORD_W-1:0] mh         = '0;    // pixel now on the pins
    logic [COORD_W-1:0] mv         = '0;
    screen_e            m_mode     = SCREEN_GAME;  // register contents
    logic [11:0]        m_bg       = BG_RESET;
    screen_e            f_mode     = SCREEN_GAME;  // settings of this frame
    logic [11:0]        f_bg       = BG_RESET;

    vga_game_top u_vga_game_top (
        .clk       (clk),
        .rst       (rst),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_wdata  (wb_wdata),
        .wb_rdata  (wb_rdata),
        .wb_ack    (wb_ack),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync),
        .vga_r     (vga_r),
        .vga_g     (vga_g),
        .vga_b     (vga_b)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 250 MHz sim clock
    end

    task automatic stop_with_failure();
        $display("Test FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
            stop_with_failure();
        end
    endtask

    // expected colour at the pins, blanking included
    function automatic logic [11:0] model_colour(input logic [COORD_W-1:0] h,
                                                 input logic [COORD_W-1:0] v,
                                                 input screen_e md, input logic [11:0] bg);
        logic [11:0] c;
        if (h >= HOR_PIXELS || v >= VER_PIXELS) begin
            c = COL_BLACK;
        end else if (md == SCREEN_GAME) begin
            c = bg;
        end else if (v == 11'd0) begin
            c = COL_YELLOW;
        end else if (v == VER_PIXELS - 11'd1) begin
            c = COL_RED;
        end else if (h == 11'd0) begin
            c = COL_GREEN;
        end else if (h == HOR_PIXELS - 11'd1) begin
            c = COL_BLUE;
        end else if (h >= BANNER_X0 && h <= BANNER_X1 && v >= BANNER_Y0 && v <= BANNER_Y1) begin
            c = COL_YELLOW;
            for (int i = 0; i < NUM_GLYPHS; i++) begin
                if (h >= GLYPHS[i].x0 && h < GLYPHS[i].x1 &&
                    v >= GLYPHS[i].y0 && v < GLYPHS[i].y1) begin
                    c = COL_BLACK;
                end
            end
        end else begin
            c = bg;
        end
        return c;
    endfunction

    // pixel model and pin checker
    always @(negedge clk) begin
        logic [11:0] exp_rgb;
        if (!rst) begin
            if (wb_ack && wb_we) begin  // write completed this cycle
                if (wb_adr == REG_MODE) begin
                    m_mode = screen_e'(wb_wdata[0]);
                end else if (wb_adr == REG_BG) begin
                    m_bg = wb_wdata[11:0];
                end
            end
            if (!aligned && vga_vsync && !vsync_prev) begin
                aligned = 1'b1;
                mh = '0;
                mv = VSYNC_START;
            end
            vsync_prev = vga_vsync;
            if (aligned) begin
                exp_rgb = model_colour(mh, mv, f_mode, f_bg);
                check("hsync", 32'(mh >= HSYNC_START && mh < HSYNC_END), 32'(vga_hsync));
                check("vsync", 32'(mv >= VSYNC_START && mv < VSYNC_END), 32'(vga_vsync));
                check("pixel colour", 32'(exp_rgb), 32'({vga_r, vga_g, vga_b}));
                // the counters are two pixels ahead, at the frame start
                if (mh == HOR_TOTAL - 11'd2 && mv == VER_TOTAL - 11'd1) begin
                    f_mode = m_mode;
                    f_bg   = m_bg;
                end
                if (mh == HOR_TOTAL - 11'd1) begin
                    mh = '0;
                    mv = (mv == VER_TOTAL - 11'd1) ? 11'd0 : mv + 11'd1;
                end else begin
                    mh = mh + 11'd1;
                end
            end
        end
    end

    task automatic wb_write(input logic [1:0] adr, input logic [31:0] data);
        int n;
        n = 0;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= 1'b1;
        wb_adr   <= adr;
        wb_wdata <= data;
        @(negedge clk);
        while (!wb_ack) begin
            n++;
            if (n > WB_LIMIT) begin
                $display("no acknowledge on write to address %0d", adr);
                stop_with_failure();
            end
            @(negedge clk);
        end
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_read(input logic [1:0] adr, output logic [31:0] data);
        int n;
        n = 0;
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= 1'b0;
        wb_adr <= adr;
        @(negedge clk);
        while (!wb_ack) begin
            n++;
            if (n > WB_LIMIT) begin
                $display("no acknowledge on read of address %0d", adr);
                stop_with_failure();
            end
            @(negedge clk);
        end
        data = wb_rdata;  // valid while ack is high
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
    endtask

    task automatic wait_vsync_rise();
        int   n;
        logic prev;
        n = 0;
        @(negedge clk);
        prev = vga_vsync;
        @(negedge clk);
        while (!(vga_vsync && !prev)) begin
            n++;
            if (n > SYNC_LIMIT) begin
                $display("vsync never rose at the pins");
                stop_with_failure();
            end
            prev = vga_vsync;
            @(negedge clk);
        end
    endtask

    // also covers the first alignment of the model
    task automatic wait_line(input logic [COORD_W-1:0] line);
        int n;
        n = 0;
        @(negedge clk);
        while (!(aligned && mv == line)) begin
            n++;
            if (n > SYNC_LIMIT) begin
                $display("line %0d was never reached at the pins", line);
                stop_with_failure();
            end
            @(negedge clk);
        end
    endtask

    initial begin
        logic [31:0] data;
        logic [31:0] rd;
        logic [11:0] colour;
        seed     = 45;
        rst      = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = 2'd0;
        wb_wdata = 32'd0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check("pins after reset", 32'd0,
              32'({vga_hsync, vga_vsync, vga_r, vga_g, vga_b, wb_ack}));

        // register reset values and readback
        wb_read(REG_MODE, rd);
        check("mode after reset", 32'd0, rd);
        wb_read(REG_BG, rd);
        check("bg after reset", 32'(BG_RESET), rd);
        repeat (4) begin
            data = $random(seed);
            wb_write(REG_BG, data);
            wb_read(REG_BG, rd);
            check("bg readback", data & 32'h0000_0FFF, rd);
        end
        wb_write(2'd2, $random(seed));
        wb_read(2'd2, rd);
        check("unmapped read", 32'd0, rd);
        wb_read(2'd3, rd);
        check("unmapped read", 32'd0, rd);

        // game screen over one full frame, written in vertical blanking
        wait_line(VSYNC_START);
        colour = 12'($random(seed));
        wb_write(REG_BG, 32'(colour));
        wait_vsync_rise();

        // finish screen, write order picked at random
        colour = 12'($random(seed));
        if ($random(seed) & 1) begin
            wb_write(REG_MODE, 32'(SCREEN_FINISH));
            wb_write(REG_BG, 32'(colour));
        end else begin
            wb_write(REG_BG, 32'(colour));
            wb_write(REG_MODE, 32'(SCREEN_FINISH));
        end
        wb_read(REG_MODE, rd);
        check("mode readback", 32'd1, rd);
        wait_vsync_rise();

        // mid-frame write shows up only from the next frame
        wait_line(11'd300);
        colour = 12'($random(seed));
        wb_write(REG_BG, 32'(colour));
        wait_vsync_rise();
        wait_vsync_rise();

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/vga_game_props.sv
`default_nettype none
`timescale 1ns/1ps

module vga_game_props (
    input  logic              clk,
    input  logic              rst,
    input  logic              wb_cyc,
    input  logic              wb_stb,
    input  logic              wb_ack,
    input  vga_pkg::vga_sig_t pix,
    input  logic [3:0]        vga_r,
    input  logic [3:0]        vga_g,
    input  logic [3:0]        vga_b
);

    a_ack_single: assert property (@(posedge clk) disable iff (rst)
        wb_ack |=> !wb_ack)
        else $error("wb_ack held high for two cycles");

    a_ack_cause: assert property (@(posedge clk) disable iff (rst)
        $rose(wb_ack) |-> $past(wb_cyc && wb_stb))
        else $error("wb_ack raised without an active bus cycle");

    a_blank_black: assert property (@(posedge clk) disable iff (rst)
        (pix.hblnk || pix.vblnk) |=> (vga_r == 4'd0 && vga_g == 4'd0 && vga_b == 4'd0))
        else $error("colour pins not black after a blanked pixel");

endmodule

// register slave and output stage checks
bind vga_game_top vga_game_props u_props (
    .clk    (clk),
    .rst    (rst),
    .wb_cyc (wb_cyc),
    .wb_stb (wb_stb),
    .wb_ack (wb_ack),
    .pix    (pix),
    .vga_r  (vga_r),
    .vga_g  (vga_g),
    .vga_b  (vga_b)
);

`default_nettype wire

// File: src/vga_game_top.sv
`default_nettype none
`timescale 1ns/1ps

module vga_game_top (
    input  logic        clk,
    input  logic        rst,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [1:0]  wb_adr,
    input  logic [31:0] wb_wdata,
    output logic [31:0] wb_rdata,
    output logic        wb_ack,
    output logic        vga_hsync,
    output logic        vga_vsync,
    output logic [3:0]  vga_r,
    output logic [3:0]  vga_g,
    output logic [3:0]  vga_b
);

    import vga_pkg::*;

    vga_sig_t    raw;  // straight from the counters
    vga_sig_t    pix;  // coloured, not yet blanked
    screen_e     mode;
    logic [11:0] bg_colour;

    vga_timing u_timing (
        .clk (clk),
        .rst (rst),
        .raw (raw)
    );

    screen_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_wdata  (wb_wdata),
        .wb_rdata  (wb_rdata),
        .wb_ack    (wb_ack),
        .mode      (mode),
        .bg_colour (bg_colour)
    );

    finish_screen u_screen (
        .clk       (clk),
        .rst       (rst),
        .mode      (mode),
        .bg_colour (bg_colour),
        .vga_in    (raw),
        .vga_out   (pix)
    );

    vga_out_stage u_out (
        .clk       (clk),
        .rst       (rst),
        .pix       (pix),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync),
        .vga_r     (vga_r),
        .vga_g     (vga_g),
        .vga_b     (vga_b)
    );

endmodule

`default_nettype wire

// File: src/vga_out_stage.sv
`default_nettype none
`timescale 1ns/1ps

module vga_out_stage (
    input  logic              clk,
    input  logic              rst,
    input  vga_pkg::vga_sig_t pix,
    output logic              vga_hsync,
    output logic              vga_vsync,
    output logic [3:0]        vga_r,
    output logic [3:0]        vga_g,
    output logic [3:0]        vga_b
);

    import vga_pkg::*;

    logic [11:0] rgb_vis;

    // black outside the active area
    assign rgb_vis = (pix.hblnk || pix.vblnk) ? COL_BLACK : pix.rgb;

    always_ff @(posedge clk) begin
        if (rst) begin
            vga_hsync <= 1'b0;
            vga_vsync <= 1'b0;
            vga_r     <= '0;
            vga_g     <= '0;
            vga_b     <= '0;
        end else begin
            vga_hsync <= pix.hsync;
            vga_vsync <= pix.vsync;
            vga_r     <= rgb_vis[11:8];
            vga_g     <= rgb_vis[7:4];
            vga_b     <= rgb_vis[3:0];
        end
    end

endmodule

`default_nettype wire

// File: src/finish_screen.sv
`default_nettype none
`timescale 1ns/1ps

module finish_screen (
    input  logic              clk,
    input  logic              rst,
    input  vga_pkg::screen_e  mode,
    input  logic [11:0]       bg_colour,
    input  vga_pkg::vga_sig_t vga_in,
    output vga_pkg::vga_sig_t vga_out
);

    import vga_pkg::*;

    logic        frame_start;
    screen_e     mode_q;
    logic [11:0] bg_q;
    screen_e     mode_cur;  // setting in force for this pixel
    logic [11:0] bg_cur;
    logic        in_banner;
    logic [11:0] rgb_nxt;
    vga_sig_t    pix_nxt;

    function automatic logic glyph_hit(
        input logic [COORD_W-1:0] x,
        input logic [COORD_W-1:0] y
    );
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < NUM_GLYPHS; i++) begin
            if (x >= GLYPHS[i].x0 && x < GLYPHS[i].x1 &&
                y >= GLYPHS[i].y0 && y < GLYPHS[i].y1) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    assign frame_start = (vga_in.hcount == '0) && (vga_in.vcount == '0);

    // the first pixel of a frame already sees the freshly sampled values
    assign mode_cur = frame_start ? mode : mode_q;
    assign bg_cur   = frame_start ? bg_colour : bg_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            mode_q <= SCREEN_GAME;
            bg_q   <= BG_RESET;
        end else if (frame_start) begin
            mode_q <= mode;
            bg_q   <= bg_colour;
        end
    end

    assign in_banner = (vga_in.hcount >= BANNER_X0) && (vga_in.hcount <= BANNER_X1) &&
                       (vga_in.vcount >= BANNER_Y0) && (vga_in.vcount <= BANNER_Y1);

    always_comb begin
        if (mode_cur == SCREEN_GAME) begin
            rgb_nxt = bg_cur;
        end else if (vga_in.vcount == '0) begin
            rgb_nxt = COL_YELLOW;  // top edge
        end else if (vga_in.vcount == VER_PIXELS - 11'd1) begin
            rgb_nxt = COL_RED;  // bottom edge
        end else if (vga_in.hcount == '0) begin
            rgb_nxt = COL_GREEN;  // left edge
        end else if (vga_in.hcount == HOR_PIXELS - 11'd1) begin
            rgb_nxt = COL_BLUE;  // right edge
        end else if (in_banner) begin
            rgb_nxt = glyph_hit(vga_in.hcount, vga_in.vcount) ? COL_BLACK : COL_YELLOW;
        end else begin
            rgb_nxt = bg_cur;
        end
    end

    always_comb begin
        pix_nxt     = vga_in;
        pix_nxt.rgb = rgb_nxt;  // blanking is left to the output stage
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vga_out <= '0;
        end else begin
            vga_out <= pix_nxt;
        end
    end

endmodule

`default_nettype wire

// File: src/screen_regs.sv
`default_nettype none
`timescale 1ns/1ps

module screen_regs (
    input  logic             clk,
    input  logic             rst,
    input  logic             wb_cyc,
    input  logic             wb_stb,
    input  logic             wb_we,
    input  logic [1:0]       wb_adr,
    input  logic [31:0]      wb_wdata,
    output logic [31:0]      wb_rdata,
    output logic             wb_ack,
    output vga_pkg::screen_e mode,
    output logic [11:0]      bg_colour
);

    import vga_pkg::*;

    logic        req;      // new access, not yet acked
    logic [31:0] rd_nxt;

    assign req = wb_cyc && wb_stb && !wb_ack;

    always_comb begin
        case (reg_addr_e'(wb_adr))
            REG_MODE: rd_nxt = {31'd0, mode};
            REG_BG:   rd_nxt = {20'd0, bg_colour};
            default:  rd_nxt = '0;  // unmapped
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack    <= 1'b0;
            mode      <= SCREEN_GAME;
            bg_colour <= BG_RESET;
        end else begin
            wb_ack <= req;  // single-cycle ack
            if (req && wb_we) begin
                case (reg_addr_e'(wb_adr))
                    REG_MODE: mode      <= screen_e'(wb_wdata[0]);
                    REG_BG:   bg_colour <= wb_wdata[11:0];
                    default:  ;  // writes ignored
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            wb_rdata <= rd_nxt;  // held while ack is high
        end
    end

endmodule

`default_nettype wire

// File: src/vga_timing.sv
`default_nettype none
`timescale 1ns/1ps

module vga_timing (
    input  logic              clk,
    input  logic              rst,
    output vga_pkg::vga_sig_t raw
);

    import vga_pkg::*;

    logic [COORD_W-1:0] h_nxt;
    logic [COORD_W-1:0] v_nxt;

    always_comb begin
        h_nxt = raw.hcount + 11'd1;
        v_nxt = raw.vcount;
        if (raw.hcount == HOR_TOTAL - 11'd1) begin  // end of line
            h_nxt = '0;
            if (raw.vcount == VER_TOTAL - 11'd1) begin
                v_nxt = '0;  // end of frame
            end else begin
                v_nxt = raw.vcount + 11'd1;
            end
        end
    end

    // flags are derived from the next count so they stay aligned with it
    always_ff @(posedge clk) begin
        if (rst) begin
            raw <= '0;  // (0,0) is active, no sync
        end else begin
            raw.hcount <= h_nxt;
            raw.vcount <= v_nxt;
            raw.hsync  <= (h_nxt >= HSYNC_START) && (h_nxt < HSYNC_END);
            raw.vsync  <= (v_nxt >= VSYNC_START) && (v_nxt < VSYNC_END);
            raw.hblnk  <= (h_nxt >= HOR_PIXELS);
            raw.vblnk  <= (v_nxt >= VER_PIXELS);
            raw.rgb    <= '0;  // colour added downstream
        end
    end

endmodule

`default_nettype wire

// File: src/vga_pkg.sv
`default_nettype none

package vga_pkg;

    localparam int COORD_W = 11;

    // 800x600 @ 60 Hz, 40 MHz pixel clock
    localparam logic [COORD_W-1:0] HOR_PIXELS  = 11'd800;
    localparam logic [COORD_W-1:0] VER_PIXELS  = 11'd600;
    localparam logic [COORD_W-1:0] HOR_TOTAL   = 11'd1056;
    localparam logic [COORD_W-1:0] VER_TOTAL   = 11'd628;
    localparam logic [COORD_W-1:0] HSYNC_START = 11'd840;
    localparam logic [COORD_W-1:0] HSYNC_END   = 11'd968;  // exclusive
    localparam logic [COORD_W-1:0] VSYNC_START = 11'd601;
    localparam logic [COORD_W-1:0] VSYNC_END   = 11'd605;  // exclusive

    typedef struct packed {
        logic [COORD_W-1:0] hcount;
        logic [COORD_W-1:0] vcount;
        logic               hsync;
        logic               vsync;
        logic               hblnk;
        logic               vblnk;
        logic [11:0]        rgb;     // r, g, b nibbles
    } vga_sig_t;

    typedef enum logic {
        SCREEN_GAME   = 1'b0,
        SCREEN_FINISH = 1'b1
    } screen_e;

    typedef enum logic [1:0] {
        REG_MODE = 2'd0,  // bit 0 selects screen
        REG_BG   = 2'd1   // 12-bit background colour
    } reg_addr_e;

    localparam logic [11:0] COL_BLACK  = 12'h000;
    localparam logic [11:0] COL_YELLOW = 12'hFF0;
    localparam logic [11:0] COL_RED    = 12'hF00;
    localparam logic [11:0] COL_GREEN  = 12'h0F0;
    localparam logic [11:0] COL_BLUE   = 12'h00F;
    localparam logic [11:0] BG_RESET   = COL_GREEN;

    // x0 and y0 inclusive, x1 and y1 exclusive
    typedef struct packed {
        logic [COORD_W-1:0] x0;
        logic [COORD_W-1:0] x1;
        logic [COORD_W-1:0] y0;
        logic [COORD_W-1:0] y1;
    } rect_t;

    // banner window, all bounds inclusive
    localparam logic [COORD_W-1:0] BANNER_X0 = 11'd161;
    localparam logic [COORD_W-1:0] BANNER_X1 = 11'd649;
    localparam logic [COORD_W-1:0] BANNER_Y0 = 11'd251;
    localparam logic [COORD_W-1:0] BANNER_Y1 = 11'd319;

    localparam int NUM_GLYPHS = 20;

    // strokes of "YOU WIN"
    localparam rect_t GLYPHS [NUM_GLYPHS] = '{
        '{11'd220, 11'd230, 11'd260, 11'd280},  // Y left arm
        '{11'd250, 11'd260, 11'd260, 11'd280},  // Y right arm
        '{11'd235, 11'd245, 11'd280, 11'd310},  // Y stem
        '{11'd275, 11'd285, 11'd260, 11'd310},  // O left
        '{11'd305, 11'd315, 11'd260, 11'd310},  // O right
        '{11'd285, 11'd305, 11'd260, 11'd270},  // O top
        '{11'd285, 11'd305, 11'd300, 11'd310},  // O bottom
        '{11'd330, 11'd340, 11'd260, 11'd310},  // U left
        '{11'd360, 11'd370, 11'd260, 11'd310},  // U right
        '{11'd340, 11'd360, 11'd300, 11'd310},  // U bottom
        '{11'd400, 11'd410, 11'd260, 11'd310},  // W left
        '{11'd430, 11'd440, 11'd260, 11'd310},  // W right
        '{11'd410, 11'd415, 11'd290, 11'd300},  // W left inner
        '{11'd425, 11'd430, 11'd290, 11'd300},  // W right inner
        '{11'd450, 11'd490, 11'd260, 11'd270},  // I top
        '{11'd465, 11'd475, 11'd270, 11'd310},  // I stem
        '{11'd450, 11'd490, 11'd300, 11'd310},  // I bottom
        '{11'd510, 11'd520, 11'd260, 11'd310},  // N left
        '{11'd540, 11'd550, 11'd260, 11'd310},  // N right
        '{11'd520, 11'd540, 11'd270, 11'd280}   // N bar
    };

endpackage

`default_nettype wire
